//--- verilog/sdcmd_cfg.svh
// Build-time sizing of the SD command-line card model, included by RTL and testbench alike
`ifndef SDCMD_CFG_SVH
`define SDCMD_CFG_SVH

// Depth of the execute command queue
// Decode starts with this many credits, so only a full queue drops a frame
`define SDCMD_CMD_CREDITS 2

// Relative card address published by CMD3
`define SDCMD_RCA_INIT 16'h1234

// Idle cycles between taking a response and driving its start bit
`define SDCMD_RSP_GAP 4

// Length of every command and response frame on the CMD line
// Start, transmission, 6 index, 32 argument, 7 CRC and the end bit
`define SDCMD_FRAME_BITS 48

`endif

//--- verilog/sdcmd_pkg.sv
// Shared types, enums and status bit positions of the SD command-line card model
`default_nettype none

package sdcmd_pkg;

    // Frame fields
    typedef logic [5:0]  cmd_idx_t;
    typedef logic [31:0] cmd_arg_t;
    typedef logic [6:0]  crc7_t;
    typedef logic [15:0] rca_t;

    // Bit position inside a 48-bit frame, also reused for the response gap
    typedef logic [5:0]  bit_cnt_t;

    // Card state as reported in status bits 12:9
    typedef enum logic [3:0] {
        CARD_IDLE  = 4'd0,
        CARD_READY = 4'd1,
        CARD_IDENT = 4'd2,
        CARD_STBY  = 4'd3
    } card_state_e;

    // Frame hunter in decode
    typedef enum logic {
        DEC_HUNT,
        DEC_RECV
    } dec_state_e;

    // Response sequencer in result
    typedef enum logic [1:0] {
        RES_IDLE,
        RES_GAP,
        RES_SEND
    } res_state_e;

    // Card status word layout
    localparam int STAT_CRC_ERR   = 23;
    localparam int STAT_ILLEGAL   = 22;
    localparam int STAT_STATE_LSB = 9;
    localparam int STAT_APP_CMD   = 5;

    // Command indices the card understands
    localparam cmd_idx_t CMD_GO_IDLE = 6'd0;
    localparam cmd_idx_t CMD_SET_RCA = 6'd3;
    localparam cmd_idx_t CMD_IF_COND = 6'd8;
    localparam cmd_idx_t CMD_STATUS  = 6'd13;
    localparam cmd_idx_t CMD_APP     = 6'd55;

endpackage

`default_nettype wire

//--- verilog/sdcmd_if.sv
// Credit-flow channels between decode, execute and result, bound together by the top level
`timescale 1ns/1ps
`default_nettype none

// Decoded command from decode to the execute queue
interface sdcmd_cmd_if import sdcmd_pkg::*; ();
    logic     valid;
    cmd_idx_t idx;
    cmd_arg_t arg;
    logic     crc_err;
    // One pulse per freed queue slot
    logic     credit;

    modport src (output valid, idx, arg, crc_err, input credit);
    modport dst (input valid, idx, arg, crc_err, output credit);
endinterface

// Built response from execute to the serializer
interface sdcmd_rsp_if import sdcmd_pkg::*; ();
    logic     valid;
    cmd_idx_t idx;
    cmd_arg_t payload;
    // Pulsed once the end bit of a response has left the card
    logic     credit;

    modport src (output valid, idx, payload, input credit);
    modport dst (input valid, idx, payload, output credit);
endinterface

`default_nettype wire

//--- verilog/sdcmd_crc7.sv
// Bit-serial CRC7 generator (x^7 + x^3 + 1), shared by the frame decoder and the serializer
`timescale 1ns/1ps
`default_nettype none

module sdcmd_crc7 import sdcmd_pkg::*; (
    input  logic  i_clk,
    input  logic  i_nrst,
    // Clear wins over shift
    input  logic  i_clear,
    input  logic  i_next,
    input  logic  i_dat,
    // Value with i_dat already folded in, so it can be latched on the last bit
    output crc7_t o_crc7
);

    crc7_t crc_q;
    crc7_t crc_n;
    logic  fb;

    // Top bit XOR data feeds taps 3 and 0
    always_comb begin
        fb    = crc_q[6] ^ i_dat;
        crc_n = {crc_q[5:3], crc_q[2] ^ fb, crc_q[1:0], fb};
    end

    assign o_crc7 = crc_n;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            crc_q <= '0;
        end else if (i_clear) begin
            crc_q <= '0;
        end else if (i_next) begin
            crc_q <= crc_n;
        end
    end

endmodule

`default_nettype wire

//--- verilog/sdcmd_decode.sv
// CMD line deserializer that frames commands, checks their CRC7 and pushes them under credit
`timescale 1ns/1ps
`default_nettype none

`include "sdcmd_cfg.svh"

module sdcmd_decode import sdcmd_pkg::*; (
    input  logic     i_clk,
    input  logic     i_nrst,
    input  logic     i_cmd_en,
    input  logic     i_cmd_bit,
    output logic     o_overrun,
    sdcmd_cmd_if.src cmd
);

    localparam int       CRED_W  = $clog2(`SDCMD_CMD_CREDITS + 1);
    localparam bit_cnt_t END_POS = bit_cnt_t'(`SDCMD_FRAME_BITS - 1);
    // First CRC bit of the frame, everything before it is covered
    localparam bit_cnt_t CRC_POS = bit_cnt_t'(`SDCMD_FRAME_BITS - 8);
    localparam bit_cnt_t LAT_POS = bit_cnt_t'(`SDCMD_FRAME_BITS - 9);

    dec_state_e        state_q;
    bit_cnt_t          pos_q;
    // Bits 1 to 46 of the frame, transmission bit on top
    logic [45:0]       sh_q;
    crc7_t             crc_calc;
    crc7_t             crc_lat_q;
    logic [CRED_W-1:0] cred_q;
    logic              end_now;
    logic              has_cred;
    logic              push_now;

    // The start bit is zero and leaves a cleared CRC unchanged, so feeding begins at bit 1
    sdcmd_crc7 u_crc7 (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (state_q == DEC_HUNT),
        .i_next  (state_q == DEC_RECV && i_cmd_en && pos_q < CRC_POS),
        .i_dat   (i_cmd_bit),
        .o_crc7  (crc_calc)
    );

    assign end_now = (state_q == DEC_RECV) && i_cmd_en && (pos_q == END_POS);

    // A credit returning in this very cycle is good enough to push
    assign has_cred = (cred_q != '0) || cmd.credit;

    // Response frames seen on the line (transmission bit 0) are ignored
    assign push_now = end_now && sh_q[45] && has_cred;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q   <= DEC_HUNT;
            pos_q     <= '0;
            cred_q    <= CRED_W'(`SDCMD_CMD_CREDITS);
            cmd.valid <= 1'b0;
            o_overrun <= 1'b0;
        end else begin
            cmd.valid <= push_now;
            o_overrun <= end_now && sh_q[45] && !has_cred;

            // Spend on push, regain on credit, both together cancel
            if (push_now && !cmd.credit) begin
                cred_q <= cred_q - 1'b1;
            end else if (!push_now && cmd.credit) begin
                cred_q <= cred_q + 1'b1;
            end

            if (i_cmd_en) begin
                case (state_q)
                    DEC_HUNT: begin
                        // Line idles high, the first low bit opens a frame
                        if (!i_cmd_bit) begin
                            state_q <= DEC_RECV;
                            pos_q   <= bit_cnt_t'(1);
                        end
                    end
                    DEC_RECV: begin
                        pos_q <= pos_q + 1'b1;
                        if (pos_q == END_POS) begin
                            state_q <= DEC_HUNT;
                        end
                    end
                    default: state_q <= DEC_HUNT;
                endcase
            end
        end
    end

    // Frame payload and the command fields it produces
    always_ff @(posedge i_clk) begin
        if (state_q == DEC_RECV && i_cmd_en) begin
            sh_q <= {sh_q[44:0], i_cmd_bit};
        end
        // Hold the computed CRC once the last covered bit has gone through
        if (state_q == DEC_RECV && i_cmd_en && pos_q == LAT_POS) begin
            crc_lat_q <= crc_calc;
        end
        if (end_now) begin
            cmd.idx     <= sh_q[44:39];
            cmd.arg     <= sh_q[38:7];
            // Bad CRC or a missing end bit both count as a CRC error
            cmd.crc_err <= (sh_q[6:0] != crc_lat_q) || !i_cmd_bit;
        end
    end

endmodule

`default_nettype wire

//--- verilog/sdcmd_execute.sv
// Command queue and card state machine that turns decoded commands into R1, R6 and R7 responses
`timescale 1ns/1ps
`default_nettype none

`include "sdcmd_cfg.svh"

module sdcmd_execute import sdcmd_pkg::*; (
    input  logic     i_clk,
    input  logic     i_nrst,
    sdcmd_cmd_if.dst cmd,
    sdcmd_rsp_if.src rsp
);

    localparam int DEPTH = `SDCMD_CMD_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Queue storage
    cmd_idx_t   q_idx [DEPTH];
    cmd_arg_t   q_arg [DEPTH];
    logic       q_err [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] q_cnt;

    // Card registers
    card_state_e card_q;
    rca_t        rca_q;
    logic        crc_flag_q;
    logic        ill_flag_q;
    logic        rsp_cred;

    // Next values worked out from the queue head
    cmd_idx_t    hd_idx;
    cmd_arg_t    hd_arg;
    card_state_e card_n;
    rca_t        rca_n;
    logic        crc_flag_n;
    logic        ill_flag_n;
    logic        app_flag_n;
    logic        rsp_go;
    cmd_arg_t    stat;
    cmd_arg_t    payload_c;
    logic        pop;

    assign hd_idx = q_idx[rd_ptr];
    assign hd_arg = q_arg[rd_ptr];

    // Every pop waits for the response slot, even when nothing will be answered
    assign pop = (q_cnt != '0) && rsp_cred;

    always_comb begin
        card_n     = card_q;
        rca_n      = rca_q;
        crc_flag_n = crc_flag_q;
        ill_flag_n = ill_flag_q;
        // Only CMD55 keeps the app flag alive
        app_flag_n = 1'b0;
        rsp_go     = 1'b0;
        payload_c  = '0;

        if (!q_err[rd_ptr] && hd_idx == CMD_APP) begin
            app_flag_n = 1'b1;
        end

        // Card status as it stands before this command
        stat                                         = '0;
        stat[STAT_CRC_ERR]                           = crc_flag_q;
        stat[STAT_ILLEGAL]                           = ill_flag_q;
        stat[STAT_STATE_LSB +: $bits(card_state_e)]  = card_q;
        stat[STAT_APP_CMD]                           = app_flag_n;

        if (q_err[rd_ptr]) begin
            crc_flag_n = 1'b1;
        end else begin
            case (hd_idx)
                CMD_GO_IDLE: begin
                    card_n     = CARD_IDLE;
                    rca_n      = '0;
                    crc_flag_n = 1'b0;
                    ill_flag_n = 1'b0;
                end
                CMD_IF_COND: begin
                    // R7 echoes voltage and check pattern
                    rsp_go    = 1'b1;
                    payload_c = {20'd0, hd_arg[11:0]};
                end
                CMD_SET_RCA: begin
                    // R6 packs the new address over a shortened status
                    rsp_go     = 1'b1;
                    rca_n      = `SDCMD_RCA_INIT;
                    card_n     = CARD_STBY;
                    payload_c  = {rca_n, stat[23], stat[22], stat[19], stat[12:0]};
                    crc_flag_n = 1'b0;
                    ill_flag_n = 1'b0;
                end
                CMD_STATUS: begin
                    // Addressed command, another card's RCA gets silence
                    if (hd_arg[31:16] == rca_q) begin
                        rsp_go     = 1'b1;
                        payload_c  = stat;
                        crc_flag_n = 1'b0;
                        ill_flag_n = 1'b0;
                    end
                end
                CMD_APP: begin
                    rsp_go     = 1'b1;
                    payload_c  = stat;
                    crc_flag_n = 1'b0;
                    ill_flag_n = 1'b0;
                end
                default: ill_flag_n = 1'b1;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            q_cnt      <= '0;
            card_q     <= CARD_IDLE;
            rca_q      <= '0;
            crc_flag_q <= 1'b0;
            ill_flag_q <= 1'b0;
            rsp_cred   <= 1'b1;
            cmd.credit <= 1'b0;
            rsp.valid  <= 1'b0;
        end else begin
            cmd.credit <= pop;
            rsp.valid  <= pop && rsp_go;

            if (cmd.valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (cmd.valid && !pop) begin
                q_cnt <= q_cnt + 1'b1;
            end else if (!cmd.valid && pop) begin
                q_cnt <= q_cnt - 1'b1;
            end

            if (pop) begin
                rd_ptr     <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                card_q     <= card_n;
                rca_q      <= rca_n;
                crc_flag_q <= crc_flag_n;
                ill_flag_q <= ill_flag_n;
            end

            // Single response in flight at a time, so spend and return never overlap
            if (pop && rsp_go) begin
                rsp_cred <= 1'b0;
            end else if (rsp.credit) begin
                rsp_cred <= 1'b1;
            end
        end
    end

    // Queue entries and the response payload
    always_ff @(posedge i_clk) begin
        if (cmd.valid) begin
            q_idx[wr_ptr] <= cmd.idx;
            q_arg[wr_ptr] <= cmd.arg;
            q_err[wr_ptr] <= cmd.crc_err;
        end
        if (pop && rsp_go) begin
            rsp.idx     <= hd_idx;
            rsp.payload <= payload_c;
        end
    end

endmodule

`default_nettype wire

//--- verilog/sdcmd_result.sv
// Response serializer that waits out the turnaround gap and drives a 48-bit frame with its CRC7
`timescale 1ns/1ps
`default_nettype none

`include "sdcmd_cfg.svh"

module sdcmd_result import sdcmd_pkg::*; (
    input  logic     i_clk,
    input  logic     i_nrst,
    sdcmd_rsp_if.dst rsp,
    output logic     o_rsp_en,
    output logic     o_rsp_bit
);

    localparam bit_cnt_t GAP_LAST = bit_cnt_t'(`SDCMD_RSP_GAP - 1);
    localparam bit_cnt_t END_POS  = bit_cnt_t'(`SDCMD_FRAME_BITS - 1);
    localparam bit_cnt_t CRC_POS  = bit_cnt_t'(`SDCMD_FRAME_BITS - 8);
    localparam bit_cnt_t LAT_POS  = bit_cnt_t'(`SDCMD_FRAME_BITS - 9);

    res_state_e  state_q;
    // Gap count while waiting, bit position while sending
    bit_cnt_t    cnt_q;
    // Start, transmission, index and payload, MSB leaves first
    logic [39:0] frame_q;
    crc7_t       crc_calc;
    crc7_t       crc_sh_q;
    logic        sending;

    assign sending = (state_q == RES_SEND);

    sdcmd_crc7 u_crc7 (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (!sending),
        .i_next  (sending && cnt_q < CRC_POS),
        .i_dat   (frame_q[39]),
        .o_crc7  (crc_calc)
    );

    // Header and payload, then the CRC, then the end bit
    assign o_rsp_en  = sending;
    assign o_rsp_bit = (cnt_q < CRC_POS) ? frame_q[39] :
                       (cnt_q < END_POS) ? crc_sh_q[6] : 1'b1;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q    <= RES_IDLE;
            cnt_q      <= '0;
            rsp.credit <= 1'b0;
        end else begin
            rsp.credit <= sending && (cnt_q == END_POS);
            case (state_q)
                RES_IDLE: begin
                    if (rsp.valid) begin
                        state_q <= RES_GAP;
                        cnt_q   <= '0;
                    end
                end
                RES_GAP: begin
                    if (cnt_q == GAP_LAST) begin
                        state_q <= RES_SEND;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                RES_SEND: begin
                    // Slot goes back to execute with the end bit
                    if (cnt_q == END_POS) begin
                        state_q <= RES_IDLE;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= RES_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == RES_IDLE && rsp.valid) begin
            // Transmission bit is 0 for card-to-host frames
            frame_q <= {1'b0, 1'b0, rsp.idx, rsp.payload};
        end else if (sending) begin
            frame_q <= {frame_q[38:0], 1'b0};
        end
        // Grab the CRC on the last covered bit, shift it out afterwards
        if (sending && cnt_q == LAT_POS) begin
            crc_sh_q <= crc_calc;
        end else if (sending) begin
            crc_sh_q <= {crc_sh_q[5:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

//--- verilog/sdcmd_top.sv
// Top level of the SD card command-line model, wiring decode, execute and result together
`timescale 1ns/1ps
`default_nettype none

module sdcmd_top (
    input  logic i_clk,
    input  logic i_nrst,
    // Serial CMD line from the host, one sampled bit per enabled cycle
    input  logic i_cmd_en,
    input  logic i_cmd_bit,
    // Serial response, 48 enabled cycles per frame
    output logic o_rsp_en,
    output logic o_rsp_bit,
    output logic o_overrun
);

    sdcmd_cmd_if u_cmd_if ();
    sdcmd_rsp_if u_rsp_if ();

    sdcmd_decode u_decode (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_cmd_en  (i_cmd_en),
        .i_cmd_bit (i_cmd_bit),
        .o_overrun (o_overrun),
        .cmd       (u_cmd_if.src)
    );

    sdcmd_execute u_execute (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .cmd    (u_cmd_if.dst),
        .rsp    (u_rsp_if.src)
    );

    sdcmd_result u_result (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .rsp       (u_rsp_if.dst),
        .o_rsp_en  (o_rsp_en),
        .o_rsp_bit (o_rsp_bit)
    );

endmodule

`default_nettype wire

//--- test/sdcmd_tb_chk.sv
// Protocol assertions on the card model, attached to the top level by the bind at the bottom
`timescale 1ns/1ps
`default_nettype none

`include "sdcmd_cfg.svh"

module sdcmd_tb_chk #(
    parameter int CRED_W = $clog2(`SDCMD_CMD_CREDITS + 1)
) (
    input logic              i_clk,
    input logic              i_nrst,
    input logic              i_rsp_en,
    input logic              i_overrun,
    input logic [CRED_W-1:0] i_cmd_cred,
    input logic              i_rsp_cred,
    input logic              i_rsp_ret
);

    // Length of the current o_rsp_en run, wide enough not to wrap on a stuck enable
    logic [6:0] run_len;
    int         fail_cnt = 0;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            run_len <= '0;
        end else begin
            run_len <= i_rsp_en ? run_len + 1'b1 : '0;
        end
    end

    a_rsp_en_in_reset: assert property (@(posedge i_clk) !i_nrst |-> !i_rsp_en)
        else begin $error("o_rsp_en high during reset"); fail_cnt++; end

    // A burst may neither end early nor run past one frame
    a_burst_not_short: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $fell(i_rsp_en) |-> run_len == 7'(`SDCMD_FRAME_BITS))
        else begin $error("response burst ended early"); fail_cnt++; end
    a_burst_not_long: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_rsp_en |-> run_len < 7'(`SDCMD_FRAME_BITS))
        else begin $error("response burst too long"); fail_cnt++; end

    // Overrun is registered, so the credit it saw is the one before
    a_overrun_no_credit: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_overrun |-> $past(i_cmd_cred) == '0)
        else begin $error("overrun with decode credit left"); fail_cnt++; end

    a_cmd_cred_max: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_cmd_cred <= CRED_W'(`SDCMD_CMD_CREDITS))
        else begin $error("decode credit above its start value"); fail_cnt++; end

    // The single execute credit may only come back while it is spent
    a_rsp_cred_max: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_rsp_ret |-> !i_rsp_cred)
        else begin $error("execute credit returned while already held"); fail_cnt++; end

endmodule

bind sdcmd_top sdcmd_tb_chk u_chk (
    .i_clk      (i_clk),
    .i_nrst     (i_nrst),
    .i_rsp_en   (o_rsp_en),
    .i_overrun  (o_overrun),
    .i_cmd_cred (u_decode.cred_q),
    .i_rsp_cred (u_execute.rsp_cred),
    .i_rsp_ret  (u_rsp_if.credit)
);

`default_nettype wire

//--- test/sdcmd_tb.sv
// Directed testbench for the SD command-line card model, run as the simulation top level
`timescale 1ns/1ps
`default_nettype none

`include "sdcmd_cfg.svh"

module sdcmd_tb import sdcmd_pkg::*; ();

    localparam int   CLK_PERIOD = 20;
    localparam int   FRAME      = `SDCMD_FRAME_BITS;
    // Cycles one frame may cost: command, response, turnaround and some slack
    localparam int   FRAME_BUDGET = FRAME + FRAME + `SDCMD_RSP_GAP + 20;
    // Quiet spell after an end bit long enough for any pending response to finish
    localparam int   QUIET    = FRAME + `SDCMD_RSP_GAP + 12;
    localparam int   RSP_WAIT = 4 * QUIET;
    localparam rca_t RCA      = `SDCMD_RCA_INIT;

    logic i_clk;
    logic i_nrst;
    logic i_cmd_en;
    logic i_cmd_bit;
    logic o_rsp_en;
    logic o_rsp_bit;
    logic o_overrun;

    // Collected response frames, oldest first
    logic [47:0] rsp_q [$];
    logic [47:0] mon_sh      = '0;
    int          mon_len     = 0;
    int          ovr_cnt     = 0;
    int          frames_sent = 0;
    int          wd_cycles   = 0;
    logic [15:0] lfsr_q;

    sdcmd_top u_sdcmd_top (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_cmd_en  (i_cmd_en),
        .i_cmd_bit (i_cmd_bit),
        .o_rsp_en  (o_rsp_en),
        .o_rsp_bit (o_rsp_bit),
        .o_overrun (o_overrun)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    task automatic stop_run();
        $display("test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // 16-bit Fibonacci LFSR, taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken, newest bit lands at the LSB
    task automatic draw_bits(input int n, output cmd_arg_t v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    // Textbook CRC7, generator 0x09, MSB first over the 40 covered bits
    function automatic crc7_t crc7_ref(input logic [39:0] d);
        crc7_t c;
        logic  fb;
        int    i;
        c = '0;
        for (i = 39; i >= 0; i--) begin
            fb = c[6] ^ d[i];
            c  = {c[5:0], 1'b0};
            if (fb) begin
                c = c ^ 7'h09;
            end
        end
        return c;
    endfunction

    // R1 card status with the flags and the state at their spec positions
    function automatic cmd_arg_t exp_status(input logic crc, input logic ill, input logic app,
                                            input card_state_e st);
        cmd_arg_t s;
        s               = '0;
        s[STAT_CRC_ERR] = crc;
        s[STAT_ILLEGAL] = ill;
        s[STAT_APP_CMD] = app;
        s[12:9]         = st;
        return s;
    endfunction

    // R6 keeps only a few status bits under the published address
    function automatic cmd_arg_t exp_r6(input rca_t rca, input logic crc, input logic ill,
                                        input logic app, input card_state_e st);
        cmd_arg_t s;
        s        = '0;
        s[31:16] = rca;
        s[15]    = crc;
        s[14]    = ill;
        s[12:9]  = st;
        s[5]     = app;
        return s;
    endfunction

    task automatic check_idx(input string name, input cmd_idx_t got, input cmd_idx_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_payload(input string name, input cmd_arg_t got, input cmd_arg_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_crc(input string name, input crc7_t got, input crc7_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_state(input string name, input card_state_e got,
                               input card_state_e exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    // Host frame: start 0, transmission 1, index, argument, CRC7, end 1
    task automatic send_cmd(input cmd_idx_t idx, input cmd_arg_t arg, input logic bad_crc,
                            input int gap);
        logic [39:0] hdr;
        logic [47:0] frame;
        crc7_t       crc;
        int          i;
        hdr = {1'b0, 1'b1, idx, arg};
        crc = crc7_ref(hdr);
        // A single flipped bit is enough to break the check
        if (bad_crc) begin
            crc = crc ^ 7'h01;
        end
        frame = {hdr, crc, 1'b1};
        frames_sent++;
        for (i = FRAME - 1; i >= 0; i--) begin
            @(posedge i_clk);
            i_cmd_en  <= 1'b1;
            i_cmd_bit <= frame[i];
        end
        for (i = 0; i < gap; i++) begin
            @(posedge i_clk);
            i_cmd_en  <= 1'b0;
            i_cmd_bit <= 1'b1;
        end
    endtask

    // Pops the next collected frame and checks every field of it
    task automatic expect_rsp(input cmd_idx_t idx, input cmd_arg_t payload,
                              input logic has_state, input card_state_e st);
        logic [47:0] f;
        int          waited;
        waited = 0;
        while (rsp_q.size() == 0 && waited < RSP_WAIT) begin
            @(posedge i_clk);
            waited++;
        end
        if (rsp_q.size() == 0) begin
            $display("No response arrived for command index %0d", idx);
            stop_run();
        end
        f = rsp_q.pop_front();
        if (f[47] !== 1'b0 || f[46] !== 1'b0 || f[0] !== 1'b1) begin
            $display("Response frame has a wrong start, transmission or end bit");
            stop_run();
        end
        check_idx("rsp_idx", f[45:40], idx);
        // Card state sits in payload bits 12:9, frame bits 20:17
        if (has_state) begin
            check_state("rsp_state", card_state_e'(f[20:17]), st);
        end
        check_payload("rsp_payload", f[39:8], payload);
        check_crc("rsp_crc7", f[7:1], crc7_ref(f[47:8]));
    endtask

    task automatic expect_none();
        repeat (QUIET) @(posedge i_clk);
        if (rsp_q.size() != 0) begin
            $display("A response came back where the card should stay silent");
            stop_run();
        end
    endtask

    // Responses are shifted in at the falling edge, where the serial outputs are stable
    always @(negedge i_clk) begin
        if (i_nrst && o_rsp_en) begin
            mon_sh  = {mon_sh[46:0], o_rsp_bit};
            mon_len = mon_len + 1;
        end else if (mon_len != 0) begin
            if (mon_len != FRAME) begin
                $display("Response burst lasted %0d cycles instead of %0d", mon_len, FRAME);
                stop_run();
            end
            rsp_q.push_back(mon_sh);
            mon_len = 0;
        end
        if (i_nrst && o_overrun) begin
            ovr_cnt = ovr_cnt + 1;
        end
    end

    task automatic idle_then_if_cond();
        cmd_arg_t arg;
        int       k;
        send_cmd(CMD_GO_IDLE, '0, 1'b0, 2);
        expect_none();
        // R7 echoes only the check pattern and voltage field
        for (k = 0; k < 4; k++) begin
            draw_bits(32, arg);
            send_cmd(CMD_IF_COND, arg, 1'b0, 2);
            expect_rsp(CMD_IF_COND, {20'd0, arg[11:0]}, 1'b0, CARD_IDLE);
        end
    endtask

    task automatic rca_then_status();
        send_cmd(CMD_SET_RCA, '0, 1'b0, 2);
        expect_rsp(CMD_SET_RCA, exp_r6(RCA, 1'b0, 1'b0, 1'b0, CARD_IDLE), 1'b1, CARD_IDLE);
        send_cmd(CMD_STATUS, {RCA, 16'h0000}, 1'b0, 2);
        expect_rsp(CMD_STATUS, exp_status(1'b0, 1'b0, 1'b0, CARD_STBY), 1'b1, CARD_STBY);
        // Addressed to some other card
        send_cmd(CMD_STATUS, {~RCA, 16'h0000}, 1'b0, 2);
        expect_none();
    endtask

    task automatic crc_error_flag();
        send_cmd(CMD_STATUS, {RCA, 16'h0000}, 1'b1, 2);
        expect_none();
        send_cmd(CMD_STATUS, {RCA, 16'h0000}, 1'b0, 2);
        expect_rsp(CMD_STATUS, exp_status(1'b1, 1'b0, 1'b0, CARD_STBY), 1'b1, CARD_STBY);
        send_cmd(CMD_STATUS, {RCA, 16'h0000}, 1'b0, 2);
        expect_rsp(CMD_STATUS, exp_status(1'b0, 1'b0, 1'b0, CARD_STBY), 1'b1, CARD_STBY);
    endtask

    task automatic illegal_and_app_flags();
        // CMD2 is outside the supported set
        send_cmd(6'd2, '0, 1'b0, 2);
        expect_none();
        send_cmd(CMD_STATUS, {RCA, 16'h0000}, 1'b0, 2);
        expect_rsp(CMD_STATUS, exp_status(1'b0, 1'b1, 1'b0, CARD_STBY), 1'b1, CARD_STBY);
        send_cmd(CMD_APP, {RCA, 16'h0000}, 1'b0, 2);
        expect_rsp(CMD_APP, exp_status(1'b0, 1'b0, 1'b1, CARD_STBY), 1'b1, CARD_STBY);
        send_cmd(CMD_STATUS, {RCA, 16'h0000}, 1'b0, 2);
        expect_rsp(CMD_STATUS, exp_status(1'b0, 1'b0, 1'b0, CARD_STBY), 1'b1, CARD_STBY);
    endtask

    task automatic status_burst();
        int k;
        int n_rsp;
        ovr_cnt = 0;
        for (k = 0; k < 8; k++) begin
            send_cmd(CMD_STATUS, {RCA, 16'h0000}, 1'b0, (k == 7) ? 2 : 0);
        end
        // Every frame is either answered or dropped with an overrun pulse
        n_rsp = 8 - ovr_cnt;
        for (k = 0; k < n_rsp; k++) begin
            expect_rsp(CMD_STATUS, exp_status(1'b0, 1'b0, 1'b0, CARD_STBY), 1'b1, CARD_STBY);
        end
        expect_none();
    endtask

    initial begin
        wd_cycles = 0;
        forever begin
            @(posedge i_clk);
            wd_cycles++;
            if (wd_cycles > (frames_sent + 1) * FRAME_BUDGET) begin
                $display("Watchdog expired after %0d cycles", wd_cycles);
                stop_run();
            end
        end
    end

    // A failed bound assertion ends the run on the next clock edge
    always @(posedge i_clk) begin
        if (u_sdcmd_top.u_chk.fail_cnt != 0) begin
            $display("A bound protocol assertion failed");
            stop_run();
        end
    end

    initial begin
        i_clk     = 1'b0;
        i_nrst    = 1'b0;
        i_cmd_en  = 1'b0;
        i_cmd_bit = 1'b1;
        lfsr_q    = 16'd46;
        repeat (10) @(posedge i_clk);
        i_nrst <= 1'b1;
        @(posedge i_clk);

        idle_then_if_cond();
        rca_then_status();
        crc_error_flag();
        illegal_and_app_flags();
        status_burst();

        repeat (4) @(posedge i_clk);
        if (u_sdcmd_top.u_chk.fail_cnt == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("Bound protocol assertions reported %0d failures",
                     u_sdcmd_top.u_chk.fail_cnt);
            stop_run();
        end
    end

endmodule

`default_nettype wire

//--- sdcmd_vip.f
+incdir+verilog
verilog/sdcmd_pkg.sv
verilog/sdcmd_if.sv
verilog/sdcmd_crc7.sv
verilog/sdcmd_decode.sv
verilog/sdcmd_execute.sv
verilog/sdcmd_result.sv
verilog/sdcmd_top.sv
test/sdcmd_tb_chk.sv
test/sdcmd_tb.sv

//--- Bender.yml
package:
  name: sdcmd_vip

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/sdcmd_pkg.sv
      - verilog/sdcmd_if.sv
      - verilog/sdcmd_crc7.sv
      - verilog/sdcmd_decode.sv
      - verilog/sdcmd_execute.sv
      - verilog/sdcmd_result.sv
      - verilog/sdcmd_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/sdcmd_tb_chk.sv
      - test/sdcmd_tb.sv
